// File: common/rdwr_config.svh
// Build-time constants for the host memory exerciser.
// Included by the package and by any module that sizes logic from these values.

`ifndef RDWR_CONFIG_SVH
`define RDWR_CONFIG_SVH

// Host memory word address and data widths
`define RDWR_ADDR_W 16
`define RDWR_DATA_W 64

// Each CSR block holds 2**RDWR_CSR_IDX_W words
`define RDWR_CSR_IDX_W 3
`define RDWR_MMIO_ADDR_W 8

// Per-engine cap on requests in flight, counted from FIFO entry to response
`define RDWR_MAX_OUTSTANDING 8
`define RDWR_FIFO_DEPTH 4

// Identifies this test to software through global CSRs 0 and 1
`define RDWR_TEST_ID 128'h3f0d92ab_6c41_4e57_b8a2_19c7e54d0a36

`endif

// File: common/rdwr_pkg.sv
// Shared types for the MMIO channel, the host memory ports and engine control.
// Modules take these by a wildcard import in their header.

`default_nettype none

`include "rdwr_config.svh"

package rdwr_pkg;

    // One MMIO request; writes carry data, reads ignore it
    typedef struct packed {
        logic                         wr;
        logic [`RDWR_MMIO_ADDR_W-1:0] addr;
        logic [`RDWR_DATA_W-1:0]      data;
    } mmio_req_t;

    typedef struct packed {
        logic [`RDWR_DATA_W-1:0] data;
    } mmio_rsp_t;

    // Host memory request, addressed in words
    typedef struct packed {
        logic                    wr;
        logic [`RDWR_ADDR_W-1:0] addr;
        logic [`RDWR_DATA_W-1:0] data;
    } mem_req_t;

    // Write responses return zero data
    typedef struct packed {
        logic [`RDWR_DATA_W-1:0] data;
    } mem_rsp_t;

    // Write strobe from the CSR manager into one engine
    typedef struct packed {
        logic                       valid;
        logic [`RDWR_CSR_IDX_W-1:0] idx;
        logic [`RDWR_DATA_W-1:0]    data;
    } eng_csr_wr_t;

    typedef struct packed {
        logic                    busy;
        logic                    done;
        logic [`RDWR_ADDR_W-1:0] count;
        logic [`RDWR_DATA_W-1:0] checksum;
    } eng_status_t;

    typedef struct packed {
        logic [`RDWR_ADDR_W-1:0] base;
        logic [`RDWR_ADDR_W-1:0] count;
        logic [`RDWR_DATA_W-1:0] seed;
    } eng_cfg_t;

    typedef enum logic {
        MODE_READ  = 1'b0,
        MODE_WRITE = 1'b1
    } eng_mode_e;

endpackage

`default_nettype wire

// File: src/stream_fifo.sv
// Valid/ready FIFO of RDWR_FIFO_DEPTH entries with a configurable payload type.
// Used for the MMIO request queue and for each engine's memory request queue.

`default_nettype none
`timescale 1ns/10ps

`include "rdwr_config.svh"

module stream_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     in_valid,
    output logic          in_ready,
    input  wire payload_t in_data,
    output logic          out_valid,
    input  wire logic     out_ready,
    output payload_t      out_data
);

    localparam int DEPTH  = `RDWR_FIFO_DEPTH;
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int USED_W = $clog2(DEPTH + 1);

    payload_t          buf_mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [USED_W-1:0] used;
    logic              push;
    logic              pop;

    // Full and empty come straight from the occupancy count
    assign in_ready  = (used != USED_W'(DEPTH));
    assign out_valid = (used != '0);
    assign out_data  = buf_mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Storage is written only on a push and read at the head pointer
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            buf_mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end
        else
        begin
            // Pointers wrap explicitly so any depth works, not only powers of two
            if (push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // A simultaneous push and pop leaves the count unchanged
            if (push && !pop)
            begin
                used <= used + 1'b1;
            end
            else if (pop && !push)
            begin
                used <= used - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: engine/host_mem_rdwr_engine.sv
// One host memory traffic engine.
// Software programs base, count, seed and mode through CSR writes, then starts a run.
// The engine streams word requests to its memory port and folds read data into a checksum.

`default_nettype none
`timescale 1ns/10ps

`include "rdwr_config.svh"

module host_mem_rdwr_engine
    import rdwr_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire eng_csr_wr_t csr_wr,
    output eng_cfg_t         cfg,
    output eng_status_t      status,
    output logic             mem_req_valid,
    input  wire logic        mem_req_ready,
    output mem_req_t         mem_req,
    input  wire logic        mem_rsp_valid,
    input  wire mem_rsp_t    mem_rsp
);

    localparam int MAX_OUT = `RDWR_MAX_OUTSTANDING;
    localparam int OUT_W   = $clog2(MAX_OUT + 1);

    eng_cfg_t                cfg_q;
    eng_mode_e               mode_q;
    logic                    busy_q;
    logic                    done_q;
    logic [`RDWR_ADDR_W-1:0] issued_q;
    logic [`RDWR_ADDR_W-1:0] cmpl_q;
    logic [`RDWR_DATA_W-1:0] checksum_q;
    logic [OUT_W-1:0]        in_flight_q;

    logic     start;
    logic     gen_valid;
    logic     gen_ready;
    logic     gen_push;
    logic     rsp_take;
    mem_req_t gen_req;

    // ==================================================
    // CSR writes and run control
    // ==================================================

    // Start is only honoured from idle, so a second start mid-run has no effect
    assign start = csr_wr.valid && (csr_wr.idx == 3) && csr_wr.data[0] && !busy_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cfg_q  <= '0;
            mode_q <= MODE_READ;
        end
        else if (csr_wr.valid && !busy_q)
        begin
            // Configuration is frozen while a run is active
            case (csr_wr.idx)
                0: cfg_q.base <= csr_wr.data[`RDWR_ADDR_W-1:0];
                1: cfg_q.count <= csr_wr.data[`RDWR_ADDR_W-1:0];
                2: cfg_q.seed <= csr_wr.data;
                3: if (csr_wr.data[0]) mode_q <= eng_mode_e'(csr_wr.data[1]);
                default: ;
            endcase
        end
    end

    // ==================================================
    // Request generator
    // ==================================================

    // Stall once every request is issued or the in-flight cap is reached
    assign gen_valid = busy_q && (issued_q != cfg_q.count) && (in_flight_q != OUT_W'(MAX_OUT));
    assign gen_push  = gen_valid && gen_ready;

    // Request i targets base + i and, when writing, carries seed + i
    assign gen_req.wr   = (mode_q == MODE_WRITE);
    assign gen_req.addr = cfg_q.base + issued_q;
    assign gen_req.data = cfg_q.seed + `RDWR_DATA_W'(issued_q);

    // The FIFO absorbs short bursts of memory back-pressure
    stream_fifo #(
        .payload_t(mem_req_t)
    ) u_req_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (gen_valid),
        .in_ready (gen_ready),
        .in_data  (gen_req),
        .out_valid(mem_req_valid),
        .out_ready(mem_req_ready),
        .out_data (mem_req)
    );

    // Responses only arrive for issued requests, so no ready is needed here
    assign rsp_take = mem_rsp_valid && busy_q;

    // ==================================================
    // Progress counters and checksum
    // ==================================================
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            issued_q    <= '0;
            cmpl_q      <= '0;
            checksum_q  <= '0;
            in_flight_q <= '0;
        end
        else
        begin
            if (start)
            begin
                busy_q     <= 1'b1;
                done_q     <= 1'b0;
                issued_q   <= '0;
                cmpl_q     <= '0;
                checksum_q <= '0;
            end
            else if (busy_q)
            begin
                if (gen_push)
                begin
                    issued_q <= issued_q + 1'b1;
                end
                if (rsp_take)
                begin
                    cmpl_q <= cmpl_q + 1'b1;
                    if (mode_q == MODE_READ)
                    begin
                        checksum_q <= checksum_q ^ mem_rsp.data;
                    end
                end
                // The registered count reaches the target the cycle after the last response
                if (cmpl_q == cfg_q.count)
                begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end

            // Requests count as in flight from FIFO entry until their response
            if (gen_push && !rsp_take)
            begin
                in_flight_q <= in_flight_q + 1'b1;
            end
            else if (rsp_take && !gen_push)
            begin
                in_flight_q <= in_flight_q - 1'b1;
            end
        end
    end

    assign cfg = cfg_q;
    assign status = '{busy: busy_q, done: done_q, count: cmpl_q, checksum: checksum_q};

endmodule

`default_nettype wire

// File: csr/csr_mgr.sv
// MMIO front end. Queues requests, turns writes into engine CSR strobes and
// answers reads from the global CSRs or from an engine's config and status.
// Word address bits above the CSR index select the block: 0 global, 1.. engines.

`default_nettype none
`timescale 1ns/10ps

`include "rdwr_config.svh"

module csr_mgr
    import rdwr_pkg::*;
#(
    parameter int NUM_ENGINES = 2
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        mmio_req_valid,
    output logic             mmio_req_ready,
    input  wire mmio_req_t   mmio_req,
    output logic             mmio_rsp_valid,
    input  wire logic        mmio_rsp_ready,
    output mmio_rsp_t        mmio_rsp,
    output eng_csr_wr_t      eng_csr_wr [NUM_ENGINES],
    input  wire eng_cfg_t    eng_cfg [NUM_ENGINES],
    input  wire eng_status_t eng_status [NUM_ENGINES]
);

    localparam int BLK_W = `RDWR_MMIO_ADDR_W - `RDWR_CSR_IDX_W;
    localparam logic [127:0] TEST_ID = `RDWR_TEST_ID;

    logic                       fifo_in_ready;
    logic                       head_valid;
    mmio_req_t                  head;
    logic                       pop;
    logic [BLK_W-1:0]           head_blk;
    logic [`RDWR_CSR_IDX_W-1:0] head_idx;
    logic [`RDWR_DATA_W-1:0]    rd_data;
    logic                       rsp_valid_q;
    mmio_rsp_t                  rsp_q;

    // Maps one engine CSR index onto its config and status fields
    function automatic logic [`RDWR_DATA_W-1:0] eng_read(
        input eng_cfg_t                   c,
        input eng_status_t                s,
        input logic [`RDWR_CSR_IDX_W-1:0] idx
    );
        logic [`RDWR_DATA_W-1:0] d;
        d = '0;
        case (idx)
            0: d = `RDWR_DATA_W'(c.base);
            1: d = `RDWR_DATA_W'(c.count);
            2: d = c.seed;
            3: d = `RDWR_DATA_W'({s.done, s.busy});
            4: d = `RDWR_DATA_W'(s.count);
            5: d = s.checksum;
            default: d = '0;
        endcase
        return d;
    endfunction

    // ==================================================
    // Request queue
    // ==================================================

    // New requests are held off while a read response waits for the host
    assign mmio_req_ready = fifo_in_ready && !rsp_valid_q;

    stream_fifo #(
        .payload_t(mmio_req_t)
    ) u_req_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (mmio_req_valid && !rsp_valid_q),
        .in_ready (fifo_in_ready),
        .in_data  (mmio_req),
        .out_valid(head_valid),
        .out_ready(pop),
        .out_data (head)
    );

    // One request per cycle, and only when the response slot is free
    assign pop      = head_valid && (!rsp_valid_q || mmio_rsp_ready);
    assign head_blk = head.addr[`RDWR_MMIO_ADDR_W-1:`RDWR_CSR_IDX_W];
    assign head_idx = head.addr[`RDWR_CSR_IDX_W-1:0];

    // ==================================================
    // Write strobes and read data
    // ==================================================
    always_comb
    begin
        for (int e = 0; e < NUM_ENGINES; e++)
        begin
            // Engine e owns block e + 1, global writes go nowhere
            eng_csr_wr[e].valid = pop && head.wr && (head_blk == BLK_W'(e + 1));
            eng_csr_wr[e].idx   = head_idx;
            eng_csr_wr[e].data  = head.data;
        end
    end

    always_comb
    begin
        rd_data = '0;
        if (head_blk == '0)
        begin
            case (head_idx)
                0: rd_data = TEST_ID[63:0];
                1: rd_data = TEST_ID[127:64];
                2: rd_data = `RDWR_DATA_W'(NUM_ENGINES);
                default: rd_data = '0;
            endcase
        end
        else
        begin
            // Blocks past the last engine fall through and read zero
            for (int e = 0; e < NUM_ENGINES; e++)
            begin
                if (head_blk == BLK_W'(e + 1))
                begin
                    rd_data = eng_read(eng_cfg[e], eng_status[e], head_idx);
                end
            end
        end
    end

    // Read response register, held until the host takes it
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rsp_valid_q <= 1'b0;
        end
        else if (pop && !head.wr)
        begin
            rsp_valid_q <= 1'b1;
        end
        else if (mmio_rsp_ready)
        begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop && !head.wr)
        begin
            rsp_q.data <= rd_data;
        end
    end

    assign mmio_rsp_valid = rsp_valid_q;
    assign mmio_rsp       = rsp_q;

endmodule

`default_nettype wire

// File: src/rdwr_afu.sv
// Top level of the host memory exerciser.
// Connects the MMIO channel to the CSR manager and gives each of the two
// engines its own host memory port.

`default_nettype none
`timescale 1ns/10ps

module rdwr_afu
    import rdwr_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    // MMIO channel
    input  wire logic      mmio_req_valid,
    output logic           mmio_req_ready,
    input  wire mmio_req_t mmio_req,
    output logic           mmio_rsp_valid,
    input  wire logic      mmio_rsp_ready,
    output mmio_rsp_t      mmio_rsp,
    // Engine 0 memory port
    output logic           e0_mem_req_valid,
    input  wire logic      e0_mem_req_ready,
    output mem_req_t       e0_mem_req,
    input  wire logic      e0_mem_rsp_valid,
    input  wire mem_rsp_t  e0_mem_rsp,
    // Engine 1 memory port
    output logic           e1_mem_req_valid,
    input  wire logic      e1_mem_req_ready,
    output mem_req_t       e1_mem_req,
    input  wire logic      e1_mem_rsp_valid,
    input  wire mem_rsp_t  e1_mem_rsp
);

    localparam int NUM_ENGINES = 2;

    eng_csr_wr_t eng_csr_wr [NUM_ENGINES];
    eng_cfg_t    eng_cfg [NUM_ENGINES];
    eng_status_t eng_status [NUM_ENGINES];

    // ==================================================
    // CSR manager and engines
    // ==================================================
    csr_mgr #(
        .NUM_ENGINES(NUM_ENGINES)
    ) u_csr_mgr (
        .clk           (clk),
        .rst_n         (rst_n),
        .mmio_req_valid(mmio_req_valid),
        .mmio_req_ready(mmio_req_ready),
        .mmio_req      (mmio_req),
        .mmio_rsp_valid(mmio_rsp_valid),
        .mmio_rsp_ready(mmio_rsp_ready),
        .mmio_rsp      (mmio_rsp),
        .eng_csr_wr    (eng_csr_wr),
        .eng_cfg       (eng_cfg),
        .eng_status    (eng_status)
    );

    // Engine 0 sits at MMIO words 0x08 to 0x0F
    host_mem_rdwr_engine u_eng0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_wr       (eng_csr_wr[0]),
        .cfg          (eng_cfg[0]),
        .status       (eng_status[0]),
        .mem_req_valid(e0_mem_req_valid),
        .mem_req_ready(e0_mem_req_ready),
        .mem_req      (e0_mem_req),
        .mem_rsp_valid(e0_mem_rsp_valid),
        .mem_rsp      (e0_mem_rsp)
    );

    // Engine 1 sits at MMIO words 0x10 to 0x17
    host_mem_rdwr_engine u_eng1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_wr       (eng_csr_wr[1]),
        .cfg          (eng_cfg[1]),
        .status       (eng_status[1]),
        .mem_req_valid(e1_mem_req_valid),
        .mem_req_ready(e1_mem_req_ready),
        .mem_req      (e1_mem_req),
        .mem_rsp_valid(e1_mem_rsp_valid),
        .mem_rsp      (e1_mem_rsp)
    );

endmodule

`default_nettype wire

// File: sim/host_mem_model.sv
// Host memory model for one engine port.
// Accepts requests under random back-pressure and answers them in order after a
// random delay. The word array starts out filled with an address-derived pattern.

`default_nettype none
`timescale 1ns/10ps

`include "rdwr_config.svh"

module host_mem_model
    import rdwr_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h1
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     req_valid,
    output logic          req_ready,
    input  wire mem_req_t req,
    output logic          rsp_valid,
    output mem_rsp_t      rsp
);

    logic [`RDWR_DATA_W-1:0] mem [2**`RDWR_ADDR_W];
    logic [`RDWR_DATA_W-1:0] rsp_data_q [$];
    int unsigned             rsp_due_q [$];
    int unsigned             cycle;
    integer                  seed;
    logic                    running;

    initial
    begin
        seed      = SEED;
        cycle     = 0;
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp       = '0;
        // Every word differs, so a wrong read address shows up in the checksum
        for (int a = 0; a < 2**`RDWR_ADDR_W; a++)
        begin
            mem[a] = {16'(a), ~16'(a), 32'(a) * 32'h9e3779b1};
        end
    end

    always @(posedge clk)
    begin
        cycle++;
        running = rst_n;
        // Handshake values here are the ones from before this edge's register updates
        if (running && req_valid && req_ready)
        begin
            if (req.wr)
            begin
                mem[req.addr] = req.data;
            end
            rsp_data_q.push_back(req.wr ? 64'h0 : mem[req.addr]);
            rsp_due_q.push_back(cycle + 1 + $unsigned($random(seed)) % 4);
        end
        #1;
        req_ready = running && ($unsigned($random(seed)) % 4 != 0);
        rsp_valid = 1'b0;
        rsp       = '0;
        // Head of line blocking keeps responses in request order
        if (running && rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle)
        begin
            rsp_valid = 1'b1;
            rsp.data  = rsp_data_q.pop_front();
            void'(rsp_due_q.pop_front());
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_rdwr_afu.sv
// Testbench for the host memory exerciser.
// Drives the MMIO channel, runs both engines against host memory models and
// checks CSR reads, completions, checksums and memory contents against a model.

`default_nettype none
`timescale 1ns/10ps

`include "rdwr_config.svh"

module tb_rdwr_afu
    import rdwr_pkg::*;
();

    localparam logic [31:0]  SEED         = 32'hb63ca239;
    localparam int           MMIO_TIMEOUT = 200;
    localparam int           POLL_LIMIT   = 500;
    localparam logic [127:0] TEST_ID      = `RDWR_TEST_ID;

    logic      clk;
    logic      rst_n;
    logic      mmio_req_valid;
    logic      mmio_req_ready;
    mmio_req_t mmio_req;
    logic      mmio_rsp_valid;
    logic      mmio_rsp_ready;
    mmio_rsp_t mmio_rsp;
    logic      e0_req_valid;
    logic      e0_req_ready;
    mem_req_t  e0_req;
    logic      e0_rsp_valid;
    mem_rsp_t  e0_rsp;
    logic      e1_req_valid;
    logic      e1_req_ready;
    mem_req_t  e1_req;
    logic      e1_rsp_valid;
    mem_rsp_t  e1_rsp;
    integer    seed;
    int        errors;

    rdwr_afu u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .mmio_req_valid  (mmio_req_valid),
        .mmio_req_ready  (mmio_req_ready),
        .mmio_req        (mmio_req),
        .mmio_rsp_valid  (mmio_rsp_valid),
        .mmio_rsp_ready  (mmio_rsp_ready),
        .mmio_rsp        (mmio_rsp),
        .e0_mem_req_valid(e0_req_valid),
        .e0_mem_req_ready(e0_req_ready),
        .e0_mem_req      (e0_req),
        .e0_mem_rsp_valid(e0_rsp_valid),
        .e0_mem_rsp      (e0_rsp),
        .e1_mem_req_valid(e1_req_valid),
        .e1_mem_req_ready(e1_req_ready),
        .e1_mem_req      (e1_req),
        .e1_mem_rsp_valid(e1_rsp_valid),
        .e1_mem_rsp      (e1_rsp)
    );

    // Each memory gets its own random stream derived from the common seed
    host_mem_model #(.SEED(SEED + 1)) u_mem0 (
        .clk(clk), .rst_n(rst_n), .req_valid(e0_req_valid), .req_ready(e0_req_ready),
        .req(e0_req), .rsp_valid(e0_rsp_valid), .rsp(e0_rsp)
    );

    host_mem_model #(.SEED(SEED + 2)) u_mem1 (
        .clk(clk), .rst_n(rst_n), .req_valid(e1_req_valid), .req_ready(e1_req_ready),
        .req(e1_req), .rsp_valid(e1_rsp_valid), .rsp(e1_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================================================
    // Reporting
    // ==================================================
    task automatic finish_run();
        $display("Error count: %0d", errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        errors++;
        finish_run();
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, logic [63:0] act);
        assert (act === exp)
        else
        begin
            $display("ERR %s expected=%h actual=%h", name, exp, act);
            errors++;
        end
    endtask

    // ==================================================
    // MMIO access
    // ==================================================

    // One request, driven 1 ns after the edge; reads wait for their response
    task automatic mmio_access(input logic wr, input logic [7:0] addr,
                               input logic [63:0] wdata, output logic [63:0] rdata);
        int   t;
        logic got;
        rdata          = '0;
        mmio_req_valid = 1'b1;
        mmio_req       = '{wr: wr, addr: addr, data: wdata};
        t = 0;
        @(negedge clk);
        while (!mmio_req_ready && t < MMIO_TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (!mmio_req_ready)
            report_timeout("MMIO request was never accepted");
        @(posedge clk);
        #1;
        mmio_req_valid = 1'b0;
        if (!wr)
        begin
            t   = 0;
            got = 1'b0;
            while (!got && t < MMIO_TIMEOUT)
            begin
                // Random gaps in rsp_ready exercise the held response
                mmio_rsp_ready = ($unsigned($random(seed)) % 3) != 0;
                @(negedge clk);
                got   = mmio_rsp_valid && mmio_rsp_ready;
                rdata = mmio_rsp.data;
                @(posedge clk);
                #1;
                t++;
            end
            mmio_rsp_ready = 1'b0;
            if (!got)
                report_timeout("MMIO read response never arrived");
        end
    endtask

    task automatic csr_write(input logic [7:0] addr, input logic [63:0] data);
        logic [63:0] unused;
        mmio_access(1'b1, addr, data, unused);
    endtask

    task automatic csr_read(input logic [7:0] addr, output logic [63:0] data);
        mmio_access(1'b0, addr, 64'h0, data);
    endtask

    // ==================================================
    // Engine helpers and reference model
    // ==================================================
    function automatic logic [7:0] eng_addr(input int e, input int idx);
        return 8'((e + 1) * 8 + idx);
    endfunction

    function automatic logic [63:0] mem_word(input int e, input logic [15:0] a);
        return (e == 0) ? u_mem0.mem[a] : u_mem1.mem[a];
    endfunction

    // Expected checksum is the XOR of the words the run covers, with 16-bit wrap
    function automatic logic [63:0] region_xor(input int e, input logic [15:0] base,
                                               input logic [15:0] cnt);
        logic [63:0] x;
        x = '0;
        for (int i = 0; i < cnt; i++)
            x ^= mem_word(e, base + 16'(i));
        return x;
    endfunction

    task automatic start_engine(input int e, input logic [15:0] base, input logic [15:0] cnt,
                                input logic [63:0] data_seed, input logic wr);
        csr_write(eng_addr(e, 0), 64'(base));
        csr_write(eng_addr(e, 1), 64'(cnt));
        csr_write(eng_addr(e, 2), data_seed);
        csr_write(eng_addr(e, 3), {62'h0, wr, 1'b1});
    endtask

    task automatic wait_done(input int e);
        logic [63:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[1] && polls < POLL_LIMIT)
        begin
            csr_read(eng_addr(e, 3), st);
            polls++;
        end
        if (!st[1])
            report_timeout($sformatf("engine %0d never reported done", e));
    endtask

    task automatic check_run(input int e, input logic [15:0] cnt, input logic [63:0] sum);
        logic [63:0] d;
        csr_read(eng_addr(e, 3), d);
        check_value($sformatf("e%0d status", e), 64'h2, d);
        csr_read(eng_addr(e, 4), d);
        check_value($sformatf("e%0d completions", e), 64'(cnt), d);
        csr_read(eng_addr(e, 5), d);
        check_value($sformatf("e%0d checksum", e), sum, d);
    endtask

    // A write run leaves seed + i at base + i
    task automatic check_written(input int e, input logic [15:0] base, input logic [15:0] cnt,
                                 input logic [63:0] data_seed);
        for (int i = 0; i < cnt; i++)
            check_value($sformatf("mem%0d[%h]", e, base + 16'(i)), data_seed + 64'(i),
                        mem_word(e, base + 16'(i)));
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    task automatic run_test_sequence();
        logic [63:0] d;
        logic [63:0] exp;
        logic [15:0] base0;
        logic [15:0] base1;
        logic [15:0] cnt0;
        logic [15:0] cnt1;
        logic [63:0] ds0;
        logic [63:0] ds1;
        // Engines come out of reset idle and not done
        for (int e = 0; e < 2; e++)
        begin
            csr_read(eng_addr(e, 3), d);
            check_value($sformatf("e%0d status after reset", e), 64'h0, d);
        end

        // Global block, then writes and addresses that must read zero
        for (int a = 0; a < 8; a++)
        begin
            exp = (a == 0) ? TEST_ID[63:0] : (a == 1) ? TEST_ID[127:64] : (a == 2) ? 64'd2 : 0;
            csr_read(8'(a), d);
            check_value($sformatf("global csr %0d", a), exp, d);
        end
        csr_write(8'h04, 64'hffff_0000_a5a5_1234);
        csr_read(8'h04, d);
        check_value("global csr 4 after write", 64'h0, d);
        csr_read(8'h18, d);
        check_value("csr 0x18", 64'h0, d);
        csr_read(8'hff, d);
        check_value("csr 0xff", 64'h0, d);

        // Engine 0 writes a random region
        base0 = 16'($random(seed));
        cnt0  = 16'(1 + $unsigned($random(seed)) % 40);
        ds0   = {32'($random(seed)), 32'($random(seed))};
        start_engine(0, base0, cnt0, ds0, 1'b1);
        wait_done(0);
        check_run(0, cnt0, 64'h0);
        check_written(0, base0, cnt0, ds0);

        // Engine 0 reads the same region back
        start_engine(0, base0, cnt0, ds0, 1'b0);
        wait_done(0);
        check_run(0, cnt0, region_xor(0, base0, cnt0));
        csr_read(eng_addr(0, 0), d);
        check_value("e0 base", 64'(base0), d);
        csr_read(eng_addr(0, 1), d);
        check_value("e0 count", 64'(cnt0), d);
        csr_read(eng_addr(0, 2), d);
        check_value("e0 seed", ds0, d);

        // Both engines at once, engine 0 reading and engine 1 writing
        base0 = 16'($random(seed));
        cnt0  = 16'(1 + $unsigned($random(seed)) % 40);
        base1 = 16'($random(seed));
        cnt1  = 16'(1 + $unsigned($random(seed)) % 40);
        ds1   = {32'($random(seed)), 32'($random(seed))};
        exp   = region_xor(0, base0, cnt0);
        start_engine(0, base0, cnt0, ds0, 1'b0);
        start_engine(1, base1, cnt1, ds1, 1'b1);
        wait_done(0);
        wait_done(1);
        check_run(0, cnt0, exp);
        check_run(1, cnt1, 64'h0);
        check_written(1, base1, cnt1, ds1);

        // A second start in write mode during a read run must change nothing
        base1 = 16'($random(seed));
        exp   = region_xor(1, base1, 16'd30);
        start_engine(1, base1, 16'd30, ds1, 1'b0);
        csr_write(eng_addr(1, 3), 64'h3);
        csr_read(eng_addr(1, 3), d);
        check_value("e1 status during run", 64'h1, d);
        wait_done(1);
        check_run(1, 16'd30, exp);

        // Zero count finishes at once with nothing done
        start_engine(1, base1, 16'd0, ds1, 1'b0);
        wait_done(1);
        check_run(1, 16'd0, 64'h0);
    endtask

    initial
    begin
        seed           = SEED;
        errors         = 0;
        rst_n          = 1'b0;
        mmio_req_valid = 1'b0;
        mmio_req       = '0;
        mmio_rsp_ready = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("mmio_req_ready", 64'h1, 64'(mmio_req_ready));
        check_value("mmio_rsp_valid", 64'h0, 64'(mmio_rsp_valid));
        check_value("e0_mem_req_valid", 64'h0, 64'(e0_req_valid));
        check_value("e1_mem_req_valid", 64'h0, 64'(e1_req_valid));
        @(posedge clk);
        #1;
        run_test_sequence();
        finish_run();
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/rdwr_pkg.sv
src/stream_fifo.sv
engine/host_mem_rdwr_engine.sv
csr/csr_mgr.sv
src/rdwr_afu.sv
sim/host_mem_model.sv
sim/tb_rdwr_afu.sv

// File: Bender.yml
package:
  name: rdwr_afu

sources:
  - include_dirs:
      - common
    files:
      - common/rdwr_pkg.sv
      - src/stream_fifo.sv
      - engine/host_mem_rdwr_engine.sv
      - csr/csr_mgr.sv
      - src/rdwr_afu.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - sim/host_mem_model.sv
      - sim/tb_rdwr_afu.sv
